// ==== include/trap_cfg.svh ====
`ifndef TRAP_CFG_SVH
`define TRAP_CFG_SVH

// data and pc width
`define TRAP_XLEN 32

// machine-mode CSR addresses
`define CSR_MEPC   12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MTVEC  12'h305

// standby cycles an ECALL waits for older instructions to retire
`define TRAP_ECALL_DRAIN 3

// MRET resumes after the trapping instruction
`define TRAP_RET_OFFSET 4

`endif

// ==== verilog/trap_pkg.sv ====
`include "trap_cfg.svh"

package trap_pkg;

    // trap event selected by the arbiter
    typedef enum logic [2:0] {
        trap_none                   = 3'd0,
        trap_fencei                 = 3'd1,
        trap_ecall                  = 3'd2,
        trap_ebreak                 = 3'd3,
        trap_mret                   = 3'd4,
        trap_misaligned_instruction = 3'd5,
        trap_misaligned_load        = 3'd6,
        trap_misaligned_store       = 3'd7
    } trap_status_t;

    // mcause exception codes, interrupt bit always clear
    localparam logic [`TRAP_XLEN-1:0] mcause_misaligned_instruction = `TRAP_XLEN'd0;
    localparam logic [`TRAP_XLEN-1:0] mcause_breakpoint             = `TRAP_XLEN'd3;
    localparam logic [`TRAP_XLEN-1:0] mcause_misaligned_load        = `TRAP_XLEN'd4;
    localparam logic [`TRAP_XLEN-1:0] mcause_misaligned_store       = `TRAP_XLEN'd6;
    localparam logic [`TRAP_XLEN-1:0] mcause_ecall                  = `TRAP_XLEN'd11;

    // mtvec mode field, values 2 and 3 are reserved
    localparam logic [1:0] mtvec_mode_direct   = 2'd0;
    localparam logic [1:0] mtvec_mode_vectored = 2'd1;

    typedef struct packed {
        logic [`TRAP_XLEN-3:0] base;  // handler address bits [XLEN-1:2]
        logic [1:0]            mode;
    } mtvec_fields_t;

    // mtvec seen as a plain word or as base/mode
    typedef union packed {
        logic [`TRAP_XLEN-1:0] raw;
        mtvec_fields_t         fields;
    } mtvec_t;

endpackage

// ==== verilog/trap_cause_arbiter.sv ====
`include "trap_cfg.svh"

module trap_cause_arbiter import trap_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic                  id_ecall,
    input  logic                  id_ebreak,
    input  logic                  id_mret,
    input  logic                  id_fencei,
    input  logic                  ex_misaligned_instruction,
    input  logic                  mem_misaligned_load,
    input  logic                  mem_misaligned_store,
    input  logic [`TRAP_XLEN-1:0] id_pc,
    input  logic [`TRAP_XLEN-1:0] ex_pc,
    input  logic [`TRAP_XLEN-1:0] mem_pc,
    input  logic                  capture_hold,
    output trap_status_t          trap_status,
    output logic [`TRAP_XLEN-1:0] trap_pc
);

    trap_status_t          next_status;
    logic [`TRAP_XLEN-1:0] next_pc;

    // oldest stage wins
    always_comb begin
        next_status = trap_none;
        next_pc     = id_pc;
        if (mem_misaligned_load) begin
            next_status = trap_misaligned_load;
            next_pc     = mem_pc;
        end else if (mem_misaligned_store) begin
            next_status = trap_misaligned_store;
            next_pc     = mem_pc;
        end else if (ex_misaligned_instruction) begin
            next_status = trap_misaligned_instruction;
            next_pc     = ex_pc;
        end else if (id_mret) begin
            next_status = trap_mret;
        end else if (id_ecall) begin
            next_status = trap_ecall;
        end else if (id_ebreak) begin
            next_status = trap_ebreak;
        end else if (id_fencei) begin
            next_status = trap_fencei;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trap_status <= trap_none;
        end else if (clk_enable && !capture_hold) begin
            trap_status <= next_status;  // frozen while a sequence runs
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable && !capture_hold) begin
            trap_pc <= next_pc;
        end
    end

endmodule

// ==== verilog/trap_csr_file.sv ====
`include "trap_cfg.svh"

module trap_csr_file import trap_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic [11:0]           csr_addr,
    input  logic                  csr_write,
    input  logic [`TRAP_XLEN-1:0] csr_wdata,
    output logic [`TRAP_XLEN-1:0] csr_rdata,
    input  logic [11:0]           trap_csr_addr,
    input  logic                  trap_csr_write,
    input  logic [`TRAP_XLEN-1:0] trap_csr_wdata,
    output logic [`TRAP_XLEN-1:0] trap_csr_rdata,
    output mtvec_t                mtvec_word
);

    logic [`TRAP_XLEN-1:0] mepc;
    logic [`TRAP_XLEN-1:0] mcause;
    mtvec_t                mtvec;

    logic trap_hit_mepc, trap_hit_mcause, trap_hit_mtvec;
    logic sw_hit_mepc, sw_hit_mcause, sw_hit_mtvec;

    // reserved modes fall back to direct
    function automatic mtvec_t legal_mtvec(input logic [`TRAP_XLEN-1:0] word);
        mtvec_t v;
        v.raw = word;
        if (v.fields.mode > mtvec_mode_vectored) begin
            v.fields.mode = mtvec_mode_direct;
        end
        return v;
    endfunction

    function automatic logic [`TRAP_XLEN-1:0] read_csr(
        input logic [11:0]           addr,
        input logic [`TRAP_XLEN-1:0] mepc_q,
        input logic [`TRAP_XLEN-1:0] mcause_q,
        input mtvec_t                mtvec_q
    );
        case (addr)
            `CSR_MEPC:   return mepc_q;
            `CSR_MCAUSE: return mcause_q;
            `CSR_MTVEC:  return mtvec_q.raw;
            default:     return '0;  // unimplemented reads as zero
        endcase
    endfunction

    assign trap_hit_mepc   = trap_csr_write && (trap_csr_addr == `CSR_MEPC);
    assign trap_hit_mcause = trap_csr_write && (trap_csr_addr == `CSR_MCAUSE);
    assign trap_hit_mtvec  = trap_csr_write && (trap_csr_addr == `CSR_MTVEC);
    assign sw_hit_mepc     = csr_write && (csr_addr == `CSR_MEPC);
    assign sw_hit_mcause   = csr_write && (csr_addr == `CSR_MCAUSE);
    assign sw_hit_mtvec    = csr_write && (csr_addr == `CSR_MTVEC);

    // trap port beats software port on the same register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mepc   <= '0;
            mcause <= '0;
            mtvec  <= '0;
        end else if (clk_enable) begin
            if (trap_hit_mepc)        mepc <= trap_csr_wdata;
            else if (sw_hit_mepc)     mepc <= csr_wdata;
            if (trap_hit_mcause)      mcause <= trap_csr_wdata;
            else if (sw_hit_mcause)   mcause <= csr_wdata;
            if (trap_hit_mtvec)       mtvec <= legal_mtvec(trap_csr_wdata);
            else if (sw_hit_mtvec)    mtvec <= legal_mtvec(csr_wdata);
        end
    end

    assign csr_rdata      = read_csr(csr_addr, mepc, mcause, mtvec);
    assign trap_csr_rdata = read_csr(trap_csr_addr, mepc, mcause, mtvec);
    assign mtvec_word     = mtvec;

endmodule

// ==== verilog/trap_controller.sv ====
`include "trap_cfg.svh"

module trap_controller import trap_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  trap_status_t          trap_status,
    input  logic [`TRAP_XLEN-1:0] trap_pc,
    output logic                  capture_hold,
    output logic                  trap_csr_write,
    output logic [11:0]           trap_csr_addr,
    output logic [`TRAP_XLEN-1:0] trap_csr_wdata,
    output logic                  target_take,
    output logic                  target_is_return,
    output logic                  trap_done,
    output logic                  ic_clean,
    output logic                  debug_mode,
    output logic                  standby_mode,
    output logic                  misaligned_instruction_flush,
    output logic                  misaligned_memory_flush,
    output logic                  pth_done_flush
);

    localparam logic [3:0] st_idle             = 4'd0;
    localparam logic [3:0] st_standby_mem      = 4'd1;
    localparam logic [3:0] st_standby_wb       = 4'd2;
    localparam logic [3:0] st_standby_rtre     = 4'd3;
    localparam logic [3:0] st_ecall_mepc_write = 4'd4;
    localparam logic [3:0] st_write_mepc       = 4'd5;
    localparam logic [3:0] st_write_mcause     = 4'd6;
    localparam logic [3:0] st_read_mtvec       = 4'd7;
    localparam logic [3:0] st_goto_mtvec       = 4'd8;
    localparam logic [3:0] st_read_mepc        = 4'd9;
    localparam logic [3:0] st_return           = 4'd10;

    localparam logic [3:0] drain_last = 4'(`TRAP_ECALL_DRAIN - 1);

    logic [3:0] state, eff_state, next_state;
    logic       seq_end;    // status still stale for one cycle after a sequence
    logic [3:0] drain_cnt;

    function automatic logic [`TRAP_XLEN-1:0] mcause_code(input trap_status_t s);
        case (s)
            trap_ebreak:           return mcause_breakpoint;
            trap_ecall:            return mcause_ecall;
            trap_misaligned_load:  return mcause_misaligned_load;
            trap_misaligned_store: return mcause_misaligned_store;
            default:               return mcause_misaligned_instruction;
        endcase
    endfunction

    // cycle A acts as the first state of the sequence, so idle maps straight to it
    always_comb begin
        eff_state = state;
        if (state == st_idle && !seq_end) begin
            case (trap_status)
                trap_ecall:  eff_state = st_standby_mem;
                trap_mret:   eff_state = st_read_mepc;
                trap_ebreak,
                trap_misaligned_instruction,
                trap_misaligned_load,
                trap_misaligned_store: eff_state = st_write_mepc;
                default:     eff_state = st_idle;
            endcase
        end
    end

    always_comb begin
        trap_csr_write               = 1'b0;
        trap_csr_addr                = 12'h000;
        trap_csr_wdata               = '0;
        target_take                  = 1'b0;
        target_is_return             = 1'b0;
        trap_done                    = 1'b1;
        standby_mode                 = 1'b0;
        misaligned_instruction_flush = 1'b0;
        misaligned_memory_flush      = 1'b0;
        pth_done_flush               = 1'b0;
        next_state                   = st_idle;

        case (eff_state)
            st_standby_mem, st_standby_wb: begin
                standby_mode = 1'b1;
                trap_done    = 1'b0;
                next_state   = eff_state + 4'd1;
            end
            st_standby_rtre: begin
                standby_mode = 1'b1;
                trap_done    = 1'b0;
                next_state   = (drain_cnt == drain_last) ? st_ecall_mepc_write
                                                         : st_standby_rtre;
            end
            st_ecall_mepc_write, st_write_mepc: begin
                trap_csr_write = 1'b1;
                trap_csr_addr  = `CSR_MEPC;
                trap_csr_wdata = trap_pc;
                trap_done      = 1'b0;
                next_state     = st_write_mcause;
            end
            st_write_mcause: begin
                trap_csr_write = 1'b1;
                trap_csr_addr  = `CSR_MCAUSE;
                trap_csr_wdata = mcause_code(trap_status);
                if (trap_status != trap_ebreak) begin
                    trap_done  = 1'b0;
                    next_state = st_read_mtvec;
                end  // ebreak ends here, debug mode takes over
            end
            st_read_mtvec, st_goto_mtvec: begin
                trap_csr_addr  = `CSR_MTVEC;
                pth_done_flush = 1'b1;
                misaligned_instruction_flush = (trap_status == trap_misaligned_instruction);
                misaligned_memory_flush = (trap_status == trap_misaligned_load) ||
                                          (trap_status == trap_misaligned_store);
                target_take    = (eff_state == st_read_mtvec);
                next_state     = (eff_state == st_read_mtvec) ? st_goto_mtvec : st_idle;
            end
            st_read_mepc: begin
                trap_csr_addr = `CSR_MEPC;
                trap_done     = 1'b0;
                next_state    = st_return;
            end
            st_return: begin
                trap_csr_addr    = `CSR_MEPC;
                target_take      = 1'b1;
                target_is_return = 1'b1;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    assign capture_hold = (eff_state != st_idle);
    assign ic_clean     = (trap_status == trap_fencei);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= st_idle;
            seq_end    <= 1'b0;
            drain_cnt  <= '0;
            debug_mode <= 1'b0;
        end else if (clk_enable) begin
            state     <= next_state;
            seq_end   <= (eff_state != st_idle) && (next_state == st_idle);
            drain_cnt <= standby_mode ? drain_cnt + 4'd1 : 4'd0;
            if (eff_state == st_read_mepc) begin
                debug_mode <= 1'b0;  // mret leaves debug
            end else if (eff_state == st_write_mcause && trap_status == trap_ebreak) begin
                debug_mode <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/trap_target_unit.sv ====
`include "trap_cfg.svh"

module trap_target_unit import trap_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic                  target_take,
    input  logic                  target_is_return,
    input  logic [`TRAP_XLEN-1:0] trap_csr_rdata,
    input  mtvec_t                mtvec_word,
    output logic                  redirect_valid,
    output logic [`TRAP_XLEN-1:0] redirect_pc
);

    localparam logic [`TRAP_XLEN-1:0] ret_offset = `TRAP_RET_OFFSET;

    logic [`TRAP_XLEN-1:0] return_pc;
    logic [`TRAP_XLEN-1:0] handler_pc;

    // mepc may hold low bits from software, drop them
    assign return_pc  = {trap_csr_rdata[`TRAP_XLEN-1:2], 2'b00} + ret_offset;
    assign handler_pc = {mtvec_word.fields.base, 2'b00};  // direct mode for exceptions

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else if (clk_enable) begin
            redirect_valid <= target_take;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable && target_take) begin
            redirect_pc <= target_is_return ? return_pc : handler_pc;
        end
    end

endmodule

// ==== verilog/trap_unit_top.sv ====
`include "trap_cfg.svh"

module trap_unit_top import trap_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic                  id_ecall,
    input  logic                  id_ebreak,
    input  logic                  id_mret,
    input  logic                  id_fencei,
    input  logic                  ex_misaligned_instruction,
    input  logic                  mem_misaligned_load,
    input  logic                  mem_misaligned_store,
    input  logic [`TRAP_XLEN-1:0] id_pc,
    input  logic [`TRAP_XLEN-1:0] ex_pc,
    input  logic [`TRAP_XLEN-1:0] mem_pc,
    input  logic [11:0]           csr_addr,
    input  logic                  csr_write,
    input  logic [`TRAP_XLEN-1:0] csr_wdata,
    output logic [`TRAP_XLEN-1:0] csr_rdata,
    output logic                  trap_done,
    output logic                  ic_clean,
    output logic                  debug_mode,
    output logic                  standby_mode,
    output logic                  misaligned_instruction_flush,
    output logic                  misaligned_memory_flush,
    output logic                  pth_done_flush,
    output logic                  redirect_valid,
    output logic [`TRAP_XLEN-1:0] redirect_pc
);

    // arbiter to controller
    trap_status_t          trap_status;
    logic [`TRAP_XLEN-1:0] trap_pc;
    logic                  capture_hold;

    // controller to CSR file and target unit
    logic                  trap_csr_write;
    logic [11:0]           trap_csr_addr;
    logic [`TRAP_XLEN-1:0] trap_csr_wdata;
    logic [`TRAP_XLEN-1:0] trap_csr_rdata;
    logic                  target_take;
    logic                  target_is_return;
    mtvec_t                mtvec_word;

    trap_cause_arbiter i_arbiter (.*);

    trap_controller i_controller (.*);

    trap_csr_file i_csr_file (.*);

    trap_target_unit i_target (.*);

endmodule

// ==== sim/trap_unit_props.sv ====
module trap_unit_props (
    input logic clk,
    input logic reset,
    input logic clk_enable,
    input logic target_take,
    input logic capture_hold,
    input logic trap_done,
    input logic standby_mode,
    input logic trap_csr_write
);

    int unsigned take_failures = 0;
    int unsigned hold_failures = 0;
    int unsigned overlap_failures = 0;

    // one redirect request per sequence
    take_pulse: assert property (@(posedge clk) disable iff (reset)
        clk_enable && target_take |=> !target_take)
        else begin
            $error("target_take high for more than one cycle");
            take_failures++;
        end

    // a stalled pipeline means the arbiter is frozen, and a stall never ends a sequence
    hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        !trap_done |-> capture_hold ##1 capture_hold)
        else begin
            $error("capture_hold low during or right after a stall");
            hold_failures++;
        end

    // drain leads straight into the mepc write
    no_write_in_standby: assert property (@(posedge clk) disable iff (reset)
        standby_mode |-> !trap_csr_write ##1 (standby_mode || trap_csr_write))
        else begin
            $error("CSR trap write during standby or missing after the drain");
            overlap_failures++;
        end

endmodule

bind trap_controller trap_unit_props i_props (.*);

// ==== sim/trap_unit_tb.sv ====
`include "trap_cfg.svh"

module trap_unit_tb import trap_pkg::*; ();

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  clk_enable;
    logic                  id_ecall, id_ebreak, id_mret, id_fencei;
    logic                  ex_misaligned_instruction, mem_misaligned_load, mem_misaligned_store;
    logic [`TRAP_XLEN-1:0] id_pc, ex_pc, mem_pc, csr_wdata, csr_rdata, redirect_pc;
    logic [11:0]           csr_addr;
    logic                  csr_write, trap_done, ic_clean, debug_mode, standby_mode;
    logic                  misaligned_instruction_flush, misaligned_memory_flush;
    logic                  pth_done_flush, redirect_valid;

    logic [31:0]           rng = 32'd77306;
    logic [`TRAP_XLEN-1:0] handler;  // expected trap handler address
    int                    wait_cycles, standby_seen;
    logic                  pth_seen, instr_seen, mem_seen;

    trap_unit_top i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [`TRAP_XLEN-1:0] actual, expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at time %0t: %s, got %h expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [`TRAP_XLEN-1:0] data);
        @(posedge clk);
        csr_addr  <= addr;
        csr_write <= 1'b1;
        csr_wdata <= data;
        @(posedge clk);
        csr_write <= 1'b0;
    endtask

    task automatic expect_csr(input logic [11:0] addr, input logic [`TRAP_XLEN-1:0] expected,
                              input string what);
        @(posedge clk);
        csr_addr <= addr;
        @(negedge clk);
        check_value(csr_rdata, expected, what);
    endtask

    // flag order: load, store, instr, mret, ecall, ebreak, fencei
    task automatic pulse_flags(input logic [6:0] f);
        @(posedge clk);
        rng = lcg_next(rng);
        id_pc <= rng;
        rng = lcg_next(rng);
        ex_pc <= rng;
        rng = lcg_next(rng);
        mem_pc <= rng;
        {mem_misaligned_load, mem_misaligned_store, ex_misaligned_instruction,
         id_mret, id_ecall, id_ebreak, id_fencei} <= f;
        @(posedge clk);
        {mem_misaligned_load, mem_misaligned_store, ex_misaligned_instruction,
         id_mret, id_ecall, id_ebreak, id_fencei} <= 7'b0;
    endtask

    // first sample is cycle A, the controller's first active cycle
    task automatic wait_redirect();
        wait_cycles  = 0;
        standby_seen = 0;
        pth_seen     = 1'b0;
        instr_seen   = 1'b0;
        mem_seen     = 1'b0;
        do begin
            @(negedge clk);
            wait_cycles++;
            standby_seen += int'(standby_mode);
            pth_seen   |= pth_done_flush;
            instr_seen |= misaligned_instruction_flush;
            mem_seen   |= misaligned_memory_flush;
            if (wait_cycles > 20 && !redirect_valid) begin
                abort_run("timeout waiting for redirect_valid");
            end
        end while (!redirect_valid);
    endtask

    task automatic expect_no_redirect(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value(redirect_valid, 1'b0, "redirect_valid after the sequence");
        end
    endtask

    task automatic run_reset_checks();
        @(negedge clk);
        check_value(trap_done, 1'b1, "trap_done after reset");
        check_value({ic_clean, debug_mode, standby_mode, redirect_valid}, '0,
                    "controls after reset");
        check_value({misaligned_instruction_flush, misaligned_memory_flush, pth_done_flush}, '0,
                    "flushes after reset");
        expect_csr(`CSR_MEPC, '0, "mepc after reset");
        expect_csr(`CSR_MCAUSE, '0, "mcause after reset");
        expect_csr(`CSR_MTVEC, '0, "mtvec after reset");
    endtask

    task automatic misaligned_trap(input logic [6:0] f, input logic [`TRAP_XLEN-1:0] cause,
                                   input logic is_mem);
        pulse_flags(f);
        wait_redirect();
        check_value(wait_cycles, 4, "redirect cycle of a misaligned trap");  // A+3
        check_value(redirect_pc, handler, "handler address");
        check_value(pth_seen, 1'b1, "pth_done_flush before redirect");
        check_value(instr_seen, !is_mem, "misaligned_instruction_flush");
        check_value(mem_seen, is_mem, "misaligned_memory_flush");
        expect_no_redirect(4);
        expect_csr(`CSR_MEPC, is_mem ? mem_pc : ex_pc, "mepc of misaligned trap");
        expect_csr(`CSR_MCAUSE, cause, "mcause of misaligned trap");
    endtask

    task automatic ecall_trap();
        pulse_flags(7'b0000100);
        wait_redirect();
        check_value(standby_seen, `TRAP_ECALL_DRAIN, "standby_mode cycles of ECALL");
        check_value(wait_cycles, 7, "redirect cycle of ECALL");  // drain shifts by three
        check_value(redirect_pc, handler, "ECALL handler address");
        expect_no_redirect(4);
        expect_csr(`CSR_MEPC, id_pc, "mepc of ECALL");
        expect_csr(`CSR_MCAUSE, mcause_ecall, "mcause of ECALL");
    endtask

    task automatic ebreak_then_mret();
        int                    n;
        logic [`TRAP_XLEN-1:0] epc;
        pulse_flags(7'b0000010);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_value(redirect_valid, 1'b0, "redirect_valid during EBREAK");
            if (n == 2) begin
                check_value(trap_done, 1'b1, "trap_done in the mcause cycle of EBREAK");  // A+1
            end
            if (n > 20 && !debug_mode) abort_run("timeout waiting for debug_mode");
        end while (!debug_mode);
        expect_no_redirect(4);
        expect_csr(`CSR_MCAUSE, mcause_breakpoint, "mcause of EBREAK");
        expect_csr(`CSR_MEPC, id_pc, "mepc of EBREAK");
        rng = lcg_next(rng);
        epc = rng | 32'h3;  // low bits set on purpose
        write_csr(`CSR_MEPC, epc);
        pulse_flags(7'b0001000);
        wait_redirect();
        check_value(wait_cycles, 3, "redirect cycle of MRET");
        check_value(redirect_pc, (epc & ~32'h3) + `TRAP_RET_OFFSET, "MRET return address");
        check_value(debug_mode, 1'b0, "debug_mode after MRET");
        expect_no_redirect(4);
    endtask

    task automatic priority_and_fencei();
        // store fault beats ecall and ebreak raised together
        misaligned_trap(7'b0100110, mcause_misaligned_store, 1'b1);
        @(posedge clk);
        id_fencei <= 1'b1;
        @(negedge clk);
        check_value(ic_clean, 1'b0, "ic_clean in the flag cycle");
        @(posedge clk);
        id_fencei <= 1'b0;
        @(negedge clk);
        check_value(ic_clean, 1'b1, "ic_clean one cycle after FENCE.I");
        check_value(trap_done, 1'b1, "trap_done during FENCE.I");
        expect_no_redirect(4);
        check_value(ic_clean, 1'b0, "ic_clean after FENCE.I");
    endtask

    initial begin
        clk_enable = 1'b1;
        {mem_misaligned_load, mem_misaligned_store, ex_misaligned_instruction} = 3'b0;
        {id_mret, id_ecall, id_ebreak, id_fencei} = 4'b0;
        id_pc     = '0;
        ex_pc     = '0;
        mem_pc    = '0;
        csr_addr  = '0;
        csr_write = 1'b0;
        csr_wdata = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        run_reset_checks();
        rng = lcg_next(rng);
        handler = rng & ~32'h3;
        write_csr(`CSR_MTVEC, handler | 32'h3);  // reserved mode
        expect_csr(`CSR_MTVEC, handler, "mtvec reserved mode reads as direct");
        write_csr(`CSR_MTVEC, handler | 32'h1);  // vectored, ignored for exceptions
        expect_csr(`CSR_MTVEC, handler | 32'h1, "mtvec vectored mode");
        misaligned_trap(7'b1000000, mcause_misaligned_load, 1'b1);
        misaligned_trap(7'b0100000, mcause_misaligned_store, 1'b1);
        misaligned_trap(7'b0010000, mcause_misaligned_instruction, 1'b0);
        ecall_trap();
        ebreak_then_mret();
        priority_and_fencei();
        if (i_dut.i_controller.i_props.take_failures + i_dut.i_controller.i_props.hold_failures
            + i_dut.i_controller.i_props.overlap_failures == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("assertion failures reported by trap_unit_props");
        end
    end

endmodule

// ==== list.f ====
+incdir+include
verilog/trap_pkg.sv
verilog/trap_cause_arbiter.sv
verilog/trap_csr_file.sv
verilog/trap_controller.sv
verilog/trap_target_unit.sv
verilog/trap_unit_top.sv
sim/trap_unit_props.sv
sim/trap_unit_tb.sv

// ==== Bender.yml ====
package:
  name: trap_unit

sources:
  - include_dirs:
      - include
    files:
      - verilog/trap_pkg.sv
      - verilog/trap_cause_arbiter.sv
      - verilog/trap_csr_file.sv
      - verilog/trap_controller.sv
      - verilog/trap_target_unit.sv
      - verilog/trap_unit_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/trap_unit_props.sv
      - sim/trap_unit_tb.sv
